// File: Bender.yml
package:
  name: axi_rw

export_include_dirs:
  - common

sources:
  - target: rtl
    include_dirs:
      - common
    files:
      - common/axi_rw_pkg.sv
      - axi_rw/axi_req_stage.sv
      - axi_rw/axi_addr_stage.sv
      - axi_rw/axi_wdata_stage.sv
      - axi_rw/axi_rdata_stage.sv
      - src/axi_rw_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/axi_slave_model.sv
      - tests/axi_rw_asserts.sv
      - tests/tb_axi_rw_top.sv

// File: axi_rw/axi_addr_stage.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_addr_stage import axi_rw_pkg::*; (
  input  wire                          i_clock,
  input  wire                          i_arst_n,
  input  wire                          i_issue,
  input  wire axi_rw_op_e              i_op,
  input  wire [`AXI_RW_ADDR_W-1:0]     i_addr,
  input  wire [7:0]                    i_len,
  input  wire [2:0]                    i_size,
  output logic                         o_aw_valid,
  input  wire                          i_aw_ready,
  output logic [`AXI_RW_ADDR_W-1:0]    o_aw_addr,
  output logic [7:0]                   o_aw_len,
  output logic [2:0]                   o_aw_size,
  output logic [1:0]                   o_aw_burst,
  output logic                         o_ar_valid,
  input  wire                          i_ar_ready,
  output logic [`AXI_RW_ADDR_W-1:0]    o_ar_addr,
  output logic [7:0]                   o_ar_len,
  output logic [2:0]                   o_ar_size,
  output logic [1:0]                   o_ar_burst
);

  // one holding register serves both channels, only one is ever open.
  logic [`AXI_RW_ADDR_W-1:0] addr_q;
  logic [7:0]                len_q;
  logic [2:0]                size_q;

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_aw_valid <= 1'b0;
      o_ar_valid <= 1'b0;
    end else if (i_issue) begin
      o_aw_valid <= (i_op == AXI_RW_OP_WRITE);
      o_ar_valid <= (i_op == AXI_RW_OP_READ);
    end else begin
      if (o_aw_valid && i_aw_ready) begin
        o_aw_valid <= 1'b0;
      end
      if (o_ar_valid && i_ar_ready) begin
        o_ar_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_issue) begin
      addr_q <= (i_addr >> i_size) << i_size; // align down to the access size.
      len_q  <= i_len;
      size_q <= i_size;
    end
  end

  assign o_aw_addr  = addr_q;
  assign o_aw_len   = len_q;
  assign o_aw_size  = size_q;
  assign o_aw_burst = `AXI_RW_BURST_INCR;
  assign o_ar_addr  = addr_q;
  assign o_ar_len   = len_q;
  assign o_ar_size  = size_q;
  assign o_ar_burst = `AXI_RW_BURST_INCR;

endmodule

`default_nettype wire

// File: axi_rw/axi_rdata_stage.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_rdata_stage import axi_rw_pkg::*; (
  input  wire                          i_clock,
  input  wire                          i_arst_n,
  input  wire                          i_issue,
  input  wire axi_rw_op_e              i_op,
  input  wire                          i_r_valid,
  output logic                         o_r_ready,
  input  wire [`AXI_RW_DATA_W-1:0]     i_r_data,
  input  wire [1:0]                    i_r_resp,
  input  wire                          i_r_last,
  output axi_rw_line_t                 o_rdata,
  output logic                         o_done,
  output axi_rw_resp_e                 o_resp
);

  localparam int BEAT_W = $clog2(`AXI_RW_MAX_BEATS);

  logic [`AXI_RW_MAX_BEATS-1:0][`AXI_RW_DATA_W-1:0] line_q;
  logic [BEAT_W-1:0] beat_q;
  axi_rw_resp_e      acc_q;
  axi_rw_resp_e      beat_resp;
  axi_rw_resp_e      merged;
  logic              start;
  logic              r_fire;

  assign start     = i_issue && (i_op == AXI_RW_OP_READ);
  assign r_fire    = o_r_ready && i_r_valid;
  assign beat_resp = axi_rw_resp_e'(i_r_resp);
  // worst response wins, okay is the lowest code.
  assign merged    = (beat_resp > acc_q) ? beat_resp : acc_q;

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_r_ready <= 1'b0;
      o_done    <= 1'b0;
      beat_q    <= '0;
    end else begin
      o_done <= r_fire && i_r_last;
      if (start) begin
        o_r_ready <= 1'b1;
        beat_q    <= '0;
      end else if (r_fire) begin
        beat_q <= beat_q + 1'b1;
        if (i_r_last) begin
          o_r_ready <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (start) begin
      line_q <= '0; // unused slices read back as zero.
      acc_q  <= AXI_RW_RESP_OKAY;
    end else if (r_fire) begin
      line_q[beat_q] <= i_r_data;
      acc_q          <= merged;
    end
  end

  assign o_rdata = line_q; // held until the next read issue.
  assign o_resp  = acc_q;

endmodule

`default_nettype wire

// File: axi_rw/axi_req_stage.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_req_stage import axi_rw_pkg::*; (
  input  wire                          i_clock,
  input  wire                          i_arst_n,
  input  wire                          i_user_valid,
  input  wire axi_rw_op_e              i_user_op,
  input  wire [`AXI_RW_ADDR_W-1:0]     i_user_addr,
  input  wire axi_rw_size_e            i_user_size,
  input  wire [7:0]                    i_user_blks,
  input  wire                          i_wr_done,
  input  wire axi_rw_resp_e            i_wr_resp,
  input  wire                          i_rd_done,
  input  wire axi_rw_resp_e            i_rd_resp,
  output logic                         o_issue,
  output axi_rw_op_e                   o_op,
  output logic [`AXI_RW_ADDR_W-1:0]    o_addr,
  output logic [7:0]                   o_len,
  output logic [2:0]                   o_size,
  output logic [`AXI_RW_STRB_W-1:0]    o_strb,
  output logic                         o_user_ready,
  output axi_rw_resp_e                 o_user_resp
);

  logic                      busy_q;
  logic                      accept;
  logic                      done_hit;
  axi_rw_resp_e              done_resp;
  logic [`AXI_RW_STRB_W-1:0] strb_base;
  logic [2:0]                lane_mask;

  // byte lanes of one access, and which offset bits survive alignment.
  always_comb begin
    unique case (i_user_size)
      AXI_RW_SIZE_BYTE: begin
        strb_base = 8'h01;
        lane_mask = 3'b111;
      end
      AXI_RW_SIZE_HALF: begin
        strb_base = 8'h03;
        lane_mask = 3'b110;
      end
      AXI_RW_SIZE_WORD: begin
        strb_base = 8'h0f;
        lane_mask = 3'b100;
      end
      default: begin
        strb_base = 8'hff;
        lane_mask = 3'b000;
      end
    endcase
  end

  assign accept    = i_user_valid && !busy_q;
  assign done_hit  = busy_q && !o_user_ready &&
                     ((o_op == AXI_RW_OP_WRITE) ? i_wr_done : i_rd_done);
  assign done_resp = (o_op == AXI_RW_OP_WRITE) ? i_wr_resp : i_rd_resp;

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q       <= 1'b0;
      o_issue      <= 1'b0;
      o_user_ready <= 1'b0;
    end else begin
      o_issue      <= accept;
      o_user_ready <= done_hit;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (o_user_ready) begin
        busy_q <= 1'b0; // stays busy through the pulse cycle.
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (accept) begin
      o_op   <= i_user_op;
      o_addr <= i_user_addr;
      o_len  <= i_user_blks; // blks is already beats minus one.
      o_size <= {1'b0, i_user_size};
      o_strb <= strb_base << (i_user_addr[2:0] & lane_mask);
    end
    if (done_hit) begin
      o_user_resp <= done_resp;
    end
  end

endmodule

`default_nettype wire

// File: axi_rw/axi_wdata_stage.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_wdata_stage import axi_rw_pkg::*; (
  input  wire                          i_clock,
  input  wire                          i_arst_n,
  input  wire                          i_issue,
  input  wire axi_rw_op_e              i_op,
  input  wire [7:0]                    i_len,
  input  wire [`AXI_RW_STRB_W-1:0]     i_strb,
  input  wire axi_rw_line_t            i_wdata,
  output logic                         o_w_valid,
  input  wire                          i_w_ready,
  output logic [`AXI_RW_DATA_W-1:0]    o_w_data,
  output logic [`AXI_RW_STRB_W-1:0]    o_w_strb,
  output logic                         o_w_last,
  input  wire                          i_b_valid,
  output logic                         o_b_ready,
  input  wire [1:0]                    i_b_resp,
  output logic                         o_done,
  output axi_rw_resp_e                 o_resp
);

  localparam int BEAT_W = $clog2(`AXI_RW_MAX_BEATS);

  logic [`AXI_RW_MAX_BEATS-1:0][`AXI_RW_DATA_W-1:0] line_q;
  logic [BEAT_W-1:0]         beat_q;
  logic [BEAT_W-1:0]         last_q;
  logic [`AXI_RW_STRB_W-1:0] strb_q;
  logic                      start;
  logic                      w_fire;
  logic                      b_fire;

  assign start  = i_issue && (i_op == AXI_RW_OP_WRITE);
  assign w_fire = o_w_valid && i_w_ready;
  assign b_fire = o_b_ready && i_b_valid;

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_w_valid <= 1'b0;
      o_b_ready <= 1'b0;
      o_done    <= 1'b0;
      beat_q    <= '0;
    end else begin
      o_done <= b_fire;
      if (start) begin
        o_w_valid <= 1'b1; // w may run ahead of aw.
        beat_q    <= '0;
      end else if (w_fire) begin
        if (o_w_last) begin
          o_w_valid <= 1'b0;
          o_b_ready <= 1'b1;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
      if (b_fire) begin
        o_b_ready <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (start) begin
      line_q <= i_wdata;
      last_q <= i_len[BEAT_W-1:0];
      strb_q <= i_strb;
    end
    if (b_fire) begin
      o_resp <= axi_rw_resp_e'(i_b_resp);
    end
  end

  assign o_w_data = line_q[beat_q]; // lowest slice goes first.
  assign o_w_strb = strb_q;
  assign o_w_last = o_w_valid && (beat_q == last_q);

endmodule

`default_nettype wire

// File: common/axi_rw_config.svh
`ifndef AXI_RW_CONFIG_SVH
`define AXI_RW_CONFIG_SVH

// axi address and data bus widths.
`define AXI_RW_ADDR_W     64
`define AXI_RW_DATA_W     64
`define AXI_RW_STRB_W     (`AXI_RW_DATA_W / 8)

// one cache line and the beats it takes on the bus.
`define AXI_RW_LINE_W     512
`define AXI_RW_MAX_BEATS  8

// awburst / arburst encoding for incrementing bursts.
`define AXI_RW_BURST_INCR 2'b01

`endif

// File: common/axi_rw_pkg.sv
`default_nettype none

`include "axi_rw_config.svh"

package axi_rw_pkg;

  typedef enum logic {
    AXI_RW_OP_READ  = 1'b0,
    AXI_RW_OP_WRITE = 1'b1
  } axi_rw_op_e;

  // low two bits of axsize.
  typedef enum logic [1:0] {
    AXI_RW_SIZE_BYTE  = 2'd0,
    AXI_RW_SIZE_HALF  = 2'd1,
    AXI_RW_SIZE_WORD  = 2'd2,
    AXI_RW_SIZE_DWORD = 2'd3
  } axi_rw_size_e;

  typedef enum logic [1:0] {
    AXI_RW_RESP_OKAY   = 2'd0,
    AXI_RW_RESP_EXOKAY = 2'd1,
    AXI_RW_RESP_SLVERR = 2'd2,
    AXI_RW_RESP_DECERR = 2'd3
  } axi_rw_resp_e;

  typedef logic [`AXI_RW_LINE_W-1:0] axi_rw_line_t;

endpackage

`default_nettype wire

// File: list.f
+incdir+common
common/axi_rw_pkg.sv
axi_rw/axi_req_stage.sv
axi_rw/axi_addr_stage.sv
axi_rw/axi_wdata_stage.sv
axi_rw/axi_rdata_stage.sv
src/axi_rw_top.sv
tests/axi_slave_model.sv
tests/axi_rw_asserts.sv
tests/tb_axi_rw_top.sv

// File: src/axi_rw_top.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_rw_top import axi_rw_pkg::*; (
  input  wire                          i_clock,
  input  wire                          i_arst_n,

  input  wire                          i_user_valid,
  input  wire axi_rw_op_e              i_user_op,
  input  wire [`AXI_RW_ADDR_W-1:0]     i_user_addr,
  input  wire axi_rw_size_e            i_user_size,
  input  wire [7:0]                    i_user_blks,
  input  wire axi_rw_line_t            i_user_wdata,
  output logic                         o_user_ready,
  output axi_rw_line_t                 o_user_rdata,
  output axi_rw_resp_e                 o_user_resp,

  output logic                         o_aw_valid,
  input  wire                          i_aw_ready,
  output logic [`AXI_RW_ADDR_W-1:0]    o_aw_addr,
  output logic [7:0]                   o_aw_len,
  output logic [2:0]                   o_aw_size,
  output logic [1:0]                   o_aw_burst,

  output logic                         o_w_valid,
  input  wire                          i_w_ready,
  output logic [`AXI_RW_DATA_W-1:0]    o_w_data,
  output logic [`AXI_RW_STRB_W-1:0]    o_w_strb,
  output logic                         o_w_last,

  input  wire                          i_b_valid,
  output logic                         o_b_ready,
  input  wire [1:0]                    i_b_resp,

  output logic                         o_ar_valid,
  input  wire                          i_ar_ready,
  output logic [`AXI_RW_ADDR_W-1:0]    o_ar_addr,
  output logic [7:0]                   o_ar_len,
  output logic [2:0]                   o_ar_size,
  output logic [1:0]                   o_ar_burst,

  input  wire                          i_r_valid,
  output logic                         o_r_ready,
  input  wire [`AXI_RW_DATA_W-1:0]     i_r_data,
  input  wire [1:0]                    i_r_resp,
  input  wire                          i_r_last
);

  logic                      issue;
  axi_rw_op_e                op;
  logic [`AXI_RW_ADDR_W-1:0] addr;
  logic [7:0]                len;
  logic [2:0]                size;
  logic [`AXI_RW_STRB_W-1:0] strb;
  logic                      wr_done;
  axi_rw_resp_e              wr_resp;
  logic                      rd_done;
  axi_rw_resp_e              rd_resp;

  axi_req_stage axi_req_stage_i (
    .i_clock      (i_clock),
    .i_arst_n     (i_arst_n),
    .i_user_valid (i_user_valid),
    .i_user_op    (i_user_op),
    .i_user_addr  (i_user_addr),
    .i_user_size  (i_user_size),
    .i_user_blks  (i_user_blks),
    .i_wr_done    (wr_done),
    .i_wr_resp    (wr_resp),
    .i_rd_done    (rd_done),
    .i_rd_resp    (rd_resp),
    .o_issue      (issue),
    .o_op         (op),
    .o_addr       (addr),
    .o_len        (len),
    .o_size       (size),
    .o_strb       (strb),
    .o_user_ready (o_user_ready),
    .o_user_resp  (o_user_resp)
  );

  axi_addr_stage axi_addr_stage_i (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_issue    (issue),
    .i_op       (op),
    .i_addr     (addr),
    .i_len      (len),
    .i_size     (size),
    .o_aw_valid (o_aw_valid),
    .i_aw_ready (i_aw_ready),
    .o_aw_addr  (o_aw_addr),
    .o_aw_len   (o_aw_len),
    .o_aw_size  (o_aw_size),
    .o_aw_burst (o_aw_burst),
    .o_ar_valid (o_ar_valid),
    .i_ar_ready (i_ar_ready),
    .o_ar_addr  (o_ar_addr),
    .o_ar_len   (o_ar_len),
    .o_ar_size  (o_ar_size),
    .o_ar_burst (o_ar_burst)
  );

  axi_wdata_stage axi_wdata_stage_i (
    .i_clock   (i_clock),
    .i_arst_n  (i_arst_n),
    .i_issue   (issue),
    .i_op      (op),
    .i_len     (len),
    .i_strb    (strb),
    .i_wdata   (i_user_wdata), // requester holds the line until completion.
    .o_w_valid (o_w_valid),
    .i_w_ready (i_w_ready),
    .o_w_data  (o_w_data),
    .o_w_strb  (o_w_strb),
    .o_w_last  (o_w_last),
    .i_b_valid (i_b_valid),
    .o_b_ready (o_b_ready),
    .i_b_resp  (i_b_resp),
    .o_done    (wr_done),
    .o_resp    (wr_resp)
  );

  axi_rdata_stage axi_rdata_stage_i (
    .i_clock   (i_clock),
    .i_arst_n  (i_arst_n),
    .i_issue   (issue),
    .i_op      (op),
    .i_r_valid (i_r_valid),
    .o_r_ready (o_r_ready),
    .i_r_data  (i_r_data),
    .i_r_resp  (i_r_resp),
    .i_r_last  (i_r_last),
    .o_rdata   (o_user_rdata),
    .o_done    (rd_done),
    .o_resp    (rd_resp)
  );

endmodule

`default_nettype wire

// File: tests/axi_rw_asserts.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_rw_asserts (
  input wire                      i_clock,
  input wire                      i_arst_n,
  input wire                      o_aw_valid,
  input wire                      i_aw_ready,
  input wire [`AXI_RW_ADDR_W-1:0] o_aw_addr,
  input wire [7:0]                o_aw_len,
  input wire                      o_ar_valid,
  input wire                      i_ar_ready,
  input wire [`AXI_RW_ADDR_W-1:0] o_ar_addr,
  input wire [7:0]                o_ar_len,
  input wire                      o_w_valid,
  input wire                      i_w_ready,
  input wire [`AXI_RW_DATA_W-1:0] o_w_data,
  input wire [`AXI_RW_STRB_W-1:0] o_w_strb,
  input wire                      o_w_last,
  input wire                      o_b_ready,
  input wire                      o_r_ready,
  input wire                      o_user_ready
);

  int failures = 0; // read by the testbench at the end of the run.

  aw_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    o_aw_valid && !i_aw_ready |=> $stable(o_aw_addr) && $stable(o_aw_len))
    else begin
      $error("aw payload changed while waiting for ready");
      failures++;
    end

  ar_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    o_ar_valid && !i_ar_ready |=> $stable(o_ar_addr) && $stable(o_ar_len))
    else begin
      $error("ar payload changed while waiting for ready");
      failures++;
    end

  w_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    o_w_valid && !i_w_ready |=> $stable(o_w_data) && $stable(o_w_strb) && $stable(o_w_last))
    else begin
      $error("w payload changed while waiting for ready");
      failures++;
    end

  ready_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    o_user_ready |=> !o_user_ready)
    else begin
      $error("user ready held high for two cycles");
      failures++;
    end

  reset_quiet: assert property (@(posedge i_clock)
    !i_arst_n |-> !(o_aw_valid || o_ar_valid || o_w_valid || o_b_ready || o_r_ready ||
                    o_user_ready))
    else begin
      $error("valid or ready raised during reset");
      failures++;
    end

endmodule

bind axi_rw_top axi_rw_asserts axi_rw_asserts_i (.*);

`default_nettype wire

// File: tests/axi_rw_input.txt
# op addr size blks wseed resp (hex), op 1 is write and 0 is read.
# beat k of a write carries {2{wseed + k}}, resp is the expected o_user_resp.
1 1000 3 7 11111100 0
0 1000 3 7 0 0
1 1001 0 0 11223344 0
1 1006 1 0 55667788 0
0 1000 3 7 0 0
0 1000 3 2 0 0
0 1008 3 0 0 0
1 2000 3 3 a5a50000 0
1 2004 2 0 cafef00d 0
0 2000 3 3 0 0
1 80000000 3 3 deadbeef 2
0 80000000 3 3 0 2
0 1000 3 7 0 0
0 3000 3 1 0 0

// File: tests/axi_slave_model.sv
`default_nettype none

`include "axi_rw_config.svh"

module axi_slave_model import axi_rw_pkg::*; (
  input  wire                       i_clock,
  input  wire                       i_aw_valid,
  output logic                      o_aw_ready,
  input  wire [`AXI_RW_ADDR_W-1:0]  i_aw_addr,
  input  wire [7:0]                 i_aw_len,
  input  wire [2:0]                 i_aw_size,
  input  wire                       i_w_valid,
  output logic                      o_w_ready,
  input  wire [`AXI_RW_DATA_W-1:0]  i_w_data,
  input  wire [`AXI_RW_STRB_W-1:0]  i_w_strb,
  output logic                      o_b_valid,
  input  wire                       i_b_ready,
  output logic [1:0]                o_b_resp,
  input  wire                       i_ar_valid,
  output logic                      o_ar_ready,
  input  wire [`AXI_RW_ADDR_W-1:0]  i_ar_addr,
  input  wire [7:0]                 i_ar_len,
  input  wire [2:0]                 i_ar_size,
  output logic                      o_r_valid,
  input  wire                       i_r_ready,
  output logic [`AXI_RW_DATA_W-1:0] o_r_data,
  output logic [1:0]                o_r_resp,
  output logic                      o_r_last
);

  localparam logic [63:0] ERR_BASE = 64'h8000_0000;

  logic [7:0]  mem [logic [63:0]]; // sparse byte memory.
  integer      seed = 98267;
  logic [63:0] w_addr;
  logic [7:0]  w_len;
  logic [2:0]  w_size;
  logic [63:0] r_addr;
  logic [7:0]  r_len;
  logic [2:0]  r_size;

  task automatic random_wait();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) @(posedge i_clock);
  endtask

  function automatic logic [63:0] beat_base(input logic [63:0] a, input logic [2:0] s,
                                            input int k);
    return (a + (64'(k) << s)) & ~64'h7;
  endfunction

  initial begin
    o_aw_ready = 1'b0;
    o_w_ready  = 1'b0;
    o_b_valid  = 1'b0;
    o_b_resp   = 2'd0;
    o_ar_ready = 1'b0;
    o_r_valid  = 1'b0;
    o_r_data   = '0;
    o_r_resp   = 2'd0;
    o_r_last   = 1'b0;
  end

  always begin : write_side
    logic [63:0] base;
    @(posedge i_clock);
    if (i_aw_valid) begin
      random_wait();
      #1 o_aw_ready = 1'b1;
      @(posedge i_clock);
      w_addr = i_aw_addr;
      w_len  = i_aw_len;
      w_size = i_aw_size;
      #1 o_aw_ready = 1'b0;
      for (int k = 0; k <= w_len; k++) begin
        random_wait();
        #1 o_w_ready = 1'b1;
        do @(posedge i_clock); while (!i_w_valid);
        base = beat_base(w_addr, w_size, k);
        for (int b = 0; b < 8; b++) begin
          if (i_w_strb[b] && w_addr < ERR_BASE) mem[base + b] = i_w_data[8*b +: 8];
        end
        #1 o_w_ready = 1'b0;
      end
      random_wait();
      #1 o_b_valid = 1'b1;
      o_b_resp = (w_addr >= ERR_BASE) ? 2'd2 : 2'd0;
      do @(posedge i_clock); while (!i_b_ready);
      #1 o_b_valid = 1'b0;
    end
  end

  always begin : read_side
    logic [63:0] base;
    @(posedge i_clock);
    if (i_ar_valid) begin
      random_wait();
      #1 o_ar_ready = 1'b1;
      @(posedge i_clock);
      r_addr = i_ar_addr;
      r_len  = i_ar_len;
      r_size = i_ar_size;
      #1 o_ar_ready = 1'b0;
      for (int k = 0; k <= r_len; k++) begin
        random_wait();
        base = beat_base(r_addr, r_size, k);
        #1 o_r_valid = 1'b1;
        o_r_last = (k == r_len);
        o_r_resp = (r_addr >= ERR_BASE) ? 2'd2 : 2'd0;
        for (int b = 0; b < 8; b++) begin
          o_r_data[8*b +: 8] = (r_addr < ERR_BASE && mem.exists(base + b)) ?
                               mem[base + b] : 8'h00;
        end
        do @(posedge i_clock); while (!i_r_ready);
        #1 o_r_valid = 1'b0;
        o_r_last = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_axi_rw_top.sv
`default_nettype none

`include "axi_rw_config.svh"

module tb_axi_rw_top import axi_rw_pkg::*; ();

  logic        i_clock;
  logic        i_arst_n;
  logic        i_user_valid;
  axi_rw_op_e  i_user_op;
  logic [63:0] i_user_addr;
  axi_rw_size_e i_user_size;
  logic [7:0]  i_user_blks;
  axi_rw_line_t i_user_wdata;
  wire         o_user_ready;
  axi_rw_line_t o_user_rdata;
  axi_rw_resp_e o_user_resp;
  wire         aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  wire         ar_valid, ar_ready, r_valid, r_ready, r_last;
  wire [63:0]  aw_addr, ar_addr, w_data, r_data;
  wire [7:0]   aw_len, ar_len, w_strb;
  wire [2:0]   aw_size, ar_size;
  wire [1:0]   aw_burst, ar_burst, b_resp, r_resp;

  logic [7:0]  shadow [logic [63:0]]; // expected memory contents.
  logic [63:0] q_op[$], q_addr[$], q_size[$], q_blks[$], q_seed[$], q_resp[$];
  logic [63:0] cur_addr = '0;
  int          cur_size = 0;
  int          cur_blks = 0;
  int          w_beats  = 0;
  int          errors = 0;
  int          pulses = 0;
  int          cycles = 0;
  int          limit  = 1000000;

  axi_rw_top axi_rw_top_i (
    .i_clock(i_clock), .i_arst_n(i_arst_n),
    .i_user_valid(i_user_valid), .i_user_op(i_user_op), .i_user_addr(i_user_addr),
    .i_user_size(i_user_size), .i_user_blks(i_user_blks), .i_user_wdata(i_user_wdata),
    .o_user_ready(o_user_ready), .o_user_rdata(o_user_rdata), .o_user_resp(o_user_resp),
    .o_aw_valid(aw_valid), .i_aw_ready(aw_ready), .o_aw_addr(aw_addr), .o_aw_len(aw_len),
    .o_aw_size(aw_size), .o_aw_burst(aw_burst),
    .o_w_valid(w_valid), .i_w_ready(w_ready), .o_w_data(w_data), .o_w_strb(w_strb),
    .o_w_last(w_last), .i_b_valid(b_valid), .o_b_ready(b_ready), .i_b_resp(b_resp),
    .o_ar_valid(ar_valid), .i_ar_ready(ar_ready), .o_ar_addr(ar_addr), .o_ar_len(ar_len),
    .o_ar_size(ar_size), .o_ar_burst(ar_burst),
    .i_r_valid(r_valid), .o_r_ready(r_ready), .i_r_data(r_data), .i_r_resp(r_resp),
    .i_r_last(r_last)
  );

  axi_slave_model slave_i (
    .i_clock(i_clock),
    .i_aw_valid(aw_valid), .o_aw_ready(aw_ready), .i_aw_addr(aw_addr), .i_aw_len(aw_len),
    .i_aw_size(aw_size), .i_w_valid(w_valid), .o_w_ready(w_ready), .i_w_data(w_data),
    .i_w_strb(w_strb), .o_b_valid(b_valid), .i_b_ready(b_ready), .o_b_resp(b_resp),
    .i_ar_valid(ar_valid), .o_ar_ready(ar_ready), .i_ar_addr(ar_addr), .i_ar_len(ar_len),
    .i_ar_size(ar_size), .o_r_valid(r_valid), .i_r_ready(r_ready), .o_r_data(r_data),
    .o_r_resp(r_resp), .o_r_last(r_last)
  );

  always #50 i_clock = ~i_clock;

  always @(posedge i_clock) begin
    cycles++;
    if (o_user_ready) pulses++;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // address beats and write beats of the open request.
  always @(posedge i_clock) begin
    if (aw_valid && aw_ready) begin
      check_value("o_aw_addr", cur_addr & ~((64'd1 << cur_size) - 64'd1), aw_addr);
      check_value("o_aw_len", cur_blks, aw_len);
      check_value("o_aw_size", cur_size, aw_size);
      check_value("o_aw_burst", 2'b01, aw_burst); // incr.
    end
    if (ar_valid && ar_ready) begin
      check_value("o_ar_addr", cur_addr & ~((64'd1 << cur_size) - 64'd1), ar_addr);
      check_value("o_ar_len", cur_blks, ar_len);
      check_value("o_ar_size", cur_size, ar_size);
      check_value("o_ar_burst", 2'b01, ar_burst);
    end
    if (w_valid && w_ready) begin
      check_value("o_w_last", w_beats == cur_blks, w_last);
      w_beats = (w_beats == cur_blks) ? 0 : w_beats + 1;
    end
  end

  // lane base of beat k in an incr burst, address aligned to the access size.
  function automatic logic [63:0] lane_base(input logic [63:0] a, input int size, input int k);
    logic [63:0] bytes;
    bytes = 64'd1 << size;
    return ((a & ~(bytes - 1)) + bytes * k) & ~64'h7;
  endfunction

  task automatic model_write(input logic [63:0] a, input int size, input int blks,
                             input logic [31:0] seed);
    int          bytes;
    int          offs;
    logic [63:0] beat;
    logic [63:0] base;
    bytes = 1 << size;
    offs  = a[2:0] & ~(bytes - 1);
    for (int k = 0; k <= blks; k++) begin
      beat = {2{seed + 32'(k)}};
      base = lane_base(a, size, k);
      for (int b = offs; b < offs + bytes; b++) begin
        if (a < 64'h8000_0000) shadow[base + b] = beat[8*b +: 8];
      end
    end
  endtask

  function automatic axi_rw_line_t expected_line(input logic [63:0] a, input int size,
                                                 input int blks);
    axi_rw_line_t line;
    logic [63:0]  base;
    line = '0;
    for (int k = 0; k <= blks; k++) begin
      base = lane_base(a, size, k);
      for (int b = 0; b < 8; b++) begin
        if (a < 64'h8000_0000 && shadow.exists(base + b)) begin
          line[64*k + 8*b +: 8] = shadow[base + b];
        end
      end
    end
    return line;
  endfunction

  task automatic load_requests();
    int    fd;
    string text;
    logic [63:0] f [6];
    fd = $fopen("tests/axi_rw_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the request file tests/axi_rw_input.txt");
      errors++;
      return;
    end
    while ($fgets(text, fd)) begin
      if ($sscanf(text, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
        q_op.push_back(f[0]);
        q_addr.push_back(f[1]);
        q_size.push_back(f[2]);
        q_blks.push_back(f[3]);
        q_seed.push_back(f[4]);
        q_resp.push_back(f[5]);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    axi_rw_line_t wline;
    int           assert_fails;
    i_clock      = 1'b0;
    i_arst_n     = 1'b0;
    i_user_valid = 1'b0;
    i_user_op    = AXI_RW_OP_READ;
    i_user_addr  = '0;
    i_user_size  = AXI_RW_SIZE_BYTE;
    i_user_blks  = '0;
    i_user_wdata = '0;
    load_requests();
    limit = 16 + 200 * q_op.size();
    repeat (16) @(posedge i_clock);
    #1 i_arst_n = 1'b1;
    foreach (q_op[i]) begin
      for (int k = 0; k < `AXI_RW_MAX_BEATS; k++) begin
        wline[64*k +: 64] = {2{q_seed[i][31:0] + 32'(k)}};
      end
      @(posedge i_clock);
      #1;
      cur_addr     = q_addr[i];
      cur_size     = q_size[i];
      cur_blks     = q_blks[i];
      i_user_valid = 1'b1;
      i_user_op    = axi_rw_op_e'(q_op[i][0]);
      i_user_addr  = q_addr[i];
      i_user_size  = axi_rw_size_e'(q_size[i][1:0]);
      i_user_blks  = q_blks[i][7:0];
      i_user_wdata = wline;
      do @(posedge i_clock); while (!o_user_ready);
      check_value("o_user_resp", q_resp[i], o_user_resp);
      if (q_op[i][0]) begin
        model_write(q_addr[i], q_size[i], q_blks[i], q_seed[i][31:0]);
      end else begin
        check_value("o_user_rdata", expected_line(q_addr[i], q_size[i], q_blks[i]),
                    o_user_rdata);
      end
      #1 i_user_valid = 1'b0;
    end
    repeat (5) @(posedge i_clock);
    if (pulses != q_op.size()) begin
      errors++;
      $display("saw %0d completion pulses for %0d requests", pulses, q_op.size());
    end
    assert_fails = axi_rw_top_i.axi_rw_asserts_i.failures;
    $display("requests: %0d errors: %0d assertion failures: %0d", q_op.size(), errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
